// ==== perf_profiler.f ====
design/perf_prof_pkg.sv
design/stall_classifier.sv
design/event_decoder.sv
design/counter_bank.sv
design/perf_profiler.sv
verification/perf_profiler_checker.sv
verification/perf_profiler_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= perf_profiler_tb
RTL_TOP ?= perf_profiler
FILELIST ?= perf_profiler.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/perf_profiler_stim.txt ====
# C en.ret icache(v r)dcache(v r) haz(mis data struct long) dma(arv arr rv rlast awv awr bv) br(v miss br jalr ret)
# R index expected, W n holds inputs n cycles, K pulses clear; R and K drive en low
R 0 0
R 9 0
R 22 0
C 11 1111 0000 0000000 10100 # c1 retire, ic and dc request, branch
C 10 1001 1100 0000000 11100 # c2 ic miss edge, stall ic, branch miss
C 10 1001 0000 0000000 10010 # c3 ic still low, stall ic, jalr
C 10 1101 1100 0000000 11011 # c4 stall mispredict, ic request, ret miss
C 10 0100 0111 1100000 11010 # c5 stall data, dc miss edge, ar handshake, jalr miss
C 10 0100 0011 0000100 00001 # c6 stall struct, dma wait, ret without redirect
C 10 0101 0001 0010110 00000 # c7 stall long, dma wait, aw handshake
C 10 0100 0000 0011000 00000 # c8 stall dc, dc miss edge, dma wait, last beat
C 10 0111 0000 0000001 00000 # c9 stall dma, dc request, write response
C 10 0101 0000 0000000 00000 # c10 stall unknown
C 11 0001 1100 1100000 00000 # c11 retire under hazards, ic miss edge, ar
C 11 0101 0000 1111000 00000 # c12 ar and last beat together, dma wait
C 11 0101 0000 0011000 00000 # c13 last beat, dma wait
R 0 13
R 1 4
R 2 2
R 3 1
R 4 1
R 5 1
R 6 1
R 7 1
R 8 1
R 9 1
R 10 2
R 11 2
R 12 2
R 13 2
R 14 3
R 15 1
R 16 6
R 17 2
R 18 1
R 19 2
R 20 1
R 21 1
R 22 1
C 00 1111 1111 0010001 11111 # everything active but disabled
R 0 13
R 17 2
R 10 2
K
R 0 0
R 16 0
C 10 0101 0000 0000000 00000 # unknown stall, held long enough to saturate
W 70000
R 0 65535
R 9 65535
R 1 0

// ==== verification/perf_profiler_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module perf_profiler_tb
  import perf_prof_pkg::*;
  ();

  localparam int unsigned CNT_W = 16; // small width so saturation is reachable.
  localparam int MAX_CYC = 100000; // cycle budget for the whole run.
  localparam int DRAIN_MAX = 20;
  localparam string STIM_FILE = "verification/perf_profiler_stim.txt";

  logic clk = 1'b0;
  logic rst, en, clear, instret;
  logic icache_valid, icache_ready, dcache_valid, dcache_ready;
  logic mispredict, data_haz, struct_haz, long_haz;
  logic m_arvalid, m_arready, m_rvalid, m_rlast, m_awvalid, m_awready, m_bvalid;
  logic redirect_v, redirect_miss, br_is_br, br_is_jalr, br_is_ret;
  logic [SEL_W_C-1:0] rd_sel;
  logic [CNT_W-1:0] rd_data;
  logic chk_v, busy; // check strobe, compare outstanding.
  logic [CNT_W-1:0] chk_exp;
  int unsigned chk_cnt, err_cnt;
  int cyc = 0; // cycles since start.
  int fd, code, tb_err, idx, exp_val, n;
  bit done;
  logic [7:0] op; // stimulus line opcode.
  logic [8*160-1:0] line; // rest of a comment line.
  logic [1:0] g_ctl;
  logic [3:0] g_cache, g_haz;
  logic [6:0] g_dma;
  logic [4:0] g_br;

  always #2 clk = ~clk; // 4 ns period.

  always @(posedge clk) cyc <= cyc + 1;

  perf_profiler #(.CNT_W(CNT_W)) i_dut (.clk_i(clk), .rst_i(rst), .en_i(en)
    , .clear_i(clear), .instret_i(instret), .icache_valid_i(icache_valid)
    , .icache_ready_i(icache_ready), .dcache_valid_i(dcache_valid)
    , .dcache_ready_i(dcache_ready), .mispredict_i(mispredict), .data_haz_i(data_haz)
    , .struct_haz_i(struct_haz), .long_haz_i(long_haz), .m_arvalid_i(m_arvalid)
    , .m_arready_i(m_arready), .m_rvalid_i(m_rvalid), .m_rlast_i(m_rlast)
    , .m_awvalid_i(m_awvalid), .m_awready_i(m_awready), .m_bvalid_i(m_bvalid)
    , .redirect_v_i(redirect_v), .redirect_miss_i(redirect_miss), .br_is_br_i(br_is_br)
    , .br_is_jalr_i(br_is_jalr), .br_is_ret_i(br_is_ret), .rd_sel_i(rd_sel)
    , .rd_data_o(rd_data));

  perf_profiler_checker #(.CNT_W(CNT_W)) i_chk (.clk_i(clk), .rst_i(rst)
    , .chk_v_i(chk_v), .chk_exp_i(chk_exp), .rd_sel_i(rd_sel), .rd_data_i(rd_data)
    , .busy_o(busy), .chk_cnt_o(chk_cnt), .err_cnt_o(err_cnt));

  // one cycle of core status, field order as in the stim file.
  task automatic apply_vector(input logic [1:0] ctl, input logic [3:0] cache
    , input logic [3:0] haz, input logic [6:0] dma, input logic [4:0] br);
    {en, instret} <= ctl;
    {icache_valid, icache_ready, dcache_valid, dcache_ready} <= cache;
    {mispredict, data_haz, struct_haz, long_haz} <= haz;
    {m_arvalid, m_arready, m_rvalid, m_rlast, m_awvalid, m_awready, m_bvalid} <= dma;
    {redirect_v, redirect_miss, br_is_br, br_is_jalr, br_is_ret} <= br;
  endtask

  // disabled, caches ready, no traffic.
  task automatic drive_idle();
    apply_vector(2'b00, 4'b0101, 4'b0000, 7'b0000000, 5'b00000);
  endtask

  // keep every input as it is for n cycles.
  task automatic hold_cycles(input int cycles);
    int i;
    i = 0;
    while (i < cycles && cyc < MAX_CYC) begin
      @(posedge clk);
      chk_v <= 1'b0;
      i++;
    end
  endtask

  task automatic bad_line(input string what);
    $display("stim file has a malformed %s line near cycle %0d", what, cyc);
    tb_err++;
    done = 1'b1;
  endtask

  initial begin
    tb_err = 0;
    done = 1'b0;
    rst <= 1'b1;
    clear <= 1'b0;
    rd_sel <= '0;
    chk_v <= 1'b0;
    chk_exp <= '0;
    drive_idle();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      tb_err++;
      done = 1'b1;
    end
    while (!done) begin
      if (cyc >= MAX_CYC) begin
        $display("stimulus still running after %0d cycles, giving up", cyc);
        tb_err++;
        done = 1'b1;
      end else if ($fscanf(fd, " %c", op) != 1) begin
        done = 1'b1; // end of file.
      end else begin
        case (op)
          "#": code = $fgets(line, fd); // comment, skip rest of line.
          "C": begin
            code = $fscanf(fd, "%b %b %b %b %b", g_ctl, g_cache, g_haz, g_dma, g_br);
            if (code != 5) bad_line("C");
            @(posedge clk);
            chk_v <= 1'b0;
            apply_vector(g_ctl, g_cache, g_haz, g_dma, g_br);
          end
          "R": begin
            code = $fscanf(fd, "%d %d", idx, exp_val);
            if (code != 2) bad_line("R");
            @(posedge clk);
            drive_idle(); // reads never count.
            rd_sel <= idx[SEL_W_C-1:0];
            chk_exp <= exp_val[CNT_W-1:0];
            chk_v <= 1'b1;
          end
          "W": begin
            code = $fscanf(fd, "%d", n);
            if (code != 1) bad_line("W");
            hold_cycles(n);
          end
          "K": begin
            @(posedge clk);
            drive_idle();
            chk_v <= 1'b0;
            clear <= 1'b1;
            @(posedge clk);
            clear <= 1'b0; // one cycle pulse.
          end
          default: bad_line("unknown");
        endcase
      end
    end
    if (fd != 0) $fclose(fd);
    @(posedge clk);
    chk_v <= 1'b0;
    drive_idle();
    @(posedge clk);
    n = 0;
    while (busy && n < DRAIN_MAX) begin // last compare still in flight.
      @(posedge clk);
      n++;
    end
    if (busy) begin
      $display("last read never completed");
      tb_err++;
    end
    if (chk_cnt == 0) begin
      $display("no counter reads were checked");
      tb_err++;
    end
    $display("checks %0d, read mismatches %0d, other errors %0d", chk_cnt, err_cnt, tb_err);
    if (err_cnt == 0 && tb_err == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/perf_profiler_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module perf_profiler_checker
  import perf_prof_pkg::*;
  #(parameter int unsigned CNT_W = 16
  )
  (input wire logic clk_i
  , input wire logic rst_i
  , input wire logic chk_v_i // read issued with an expected value.
  , input wire logic [CNT_W-1:0] chk_exp_i
  , input wire logic [SEL_W_C-1:0] rd_sel_i // dut select, same cycle as strobe.
  , input wire logic [CNT_W-1:0] rd_data_i // dut read data.
  , output logic busy_o // a compare is still due.
  , output int unsigned chk_cnt_o
  , output int unsigned err_cnt_o
  );

  logic chk_v_q; // read data due this cycle.
  logic [CNT_W-1:0] exp_q;
  logic [SEL_W_C-1:0] sel_q; // counter index under test.

  // read data lags the select by one cycle.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      chk_v_q <= 1'b0;
      exp_q <= '0;
      sel_q <= '0;
    end else begin
      chk_v_q <= chk_v_i;
      exp_q <= chk_exp_i;
      sel_q <= rd_sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      chk_cnt_o <= 0;
      err_cnt_o <= 0;
    end else if (chk_v_q) begin
      chk_cnt_o <= chk_cnt_o + 1;
      if (sel_q >= NUM_CNT_C) begin
        $display("read of counter %0d at %0t is outside the counter map", sel_q, $time);
        err_cnt_o <= err_cnt_o + 1;
      end else if (rd_data_i !== exp_q) begin // catches x too.
        $display("FAIL t=%0t rd_data_o (counter %0d) expected %0d actual %0d",
          $time, sel_q, exp_q, rd_data_i);
        err_cnt_o <= err_cnt_o + 1;
      end
    end
  end

  assign busy_o = chk_v_q;

endmodule

`default_nettype wire

// ==== design/perf_profiler.sv ====
`timescale 1ns/10ps
`default_nettype none

module perf_profiler
  import perf_prof_pkg::*;
  #(parameter int unsigned CNT_W = 32
  )
  (input wire logic clk_i
  , input wire logic rst_i
  , input wire logic en_i
  , input wire logic clear_i
  , input wire logic instret_i
  , input wire logic icache_valid_i
  , input wire logic icache_ready_i
  , input wire logic dcache_valid_i
  , input wire logic dcache_ready_i
  , input wire logic mispredict_i
  , input wire logic data_haz_i
  , input wire logic struct_haz_i
  , input wire logic long_haz_i
  , input wire logic m_arvalid_i
  , input wire logic m_arready_i
  , input wire logic m_rvalid_i
  , input wire logic m_rlast_i
  , input wire logic m_awvalid_i
  , input wire logic m_awready_i
  , input wire logic m_bvalid_i
  , input wire logic redirect_v_i
  , input wire logic redirect_miss_i
  , input wire logic br_is_br_i
  , input wire logic br_is_jalr_i
  , input wire logic br_is_ret_i
  , input wire logic [SEL_W_C-1:0] rd_sel_i
  , output logic [CNT_W-1:0] rd_data_o
  );

  logic ic_miss, dc_miss, dma_pending; // decoder to classifier.
  logic cyc_inc, ret_inc;
  logic [NUM_STALL_C-1:0] stall_hot;
  logic [NUM_EVT_C-1:0] evt;
  logic [NUM_CNT_C-1:0] inc; // bank increment vector.

  assign inc[CNT_MCYCLE] = cyc_inc;
  assign inc[CNT_MINSTRET] = ret_inc;
  assign inc[CNT_STALL_BASE +: NUM_STALL_C] = stall_hot; // counters 2 to 9.
  assign inc[CNT_IC_REQ +: NUM_EVT_C] = evt; // counters 10 to 22.

  event_decoder i_evt (.clk_i, .rst_i, .en_i, .icache_valid_i, .icache_ready_i
    , .dcache_valid_i, .dcache_ready_i, .m_arvalid_i, .m_arready_i, .m_rvalid_i
    , .m_rlast_i, .m_awvalid_i, .m_awready_i, .m_bvalid_i, .redirect_v_i
    , .redirect_miss_i, .br_is_br_i, .br_is_jalr_i, .br_is_ret_i
    , .ic_miss_o(ic_miss), .dc_miss_o(dc_miss), .dma_pending_o(dma_pending)
    , .evt_o(evt));

  stall_classifier i_stall (.clk_i, .rst_i, .en_i, .instret_i, .ic_miss_i(ic_miss)
    , .mispredict_i, .data_haz_i, .struct_haz_i, .long_haz_i, .dc_miss_i(dc_miss)
    , .dma_pending_i(dma_pending), .cyc_inc_o(cyc_inc), .ret_inc_o(ret_inc)
    , .stall_hot_o(stall_hot));

  counter_bank #(.CNT_W(CNT_W)) i_bank (.clk_i, .rst_i, .clear_i, .inc_i(inc)
    , .rd_sel_i, .rd_data_o);

endmodule

`default_nettype wire

// ==== design/counter_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module counter_bank
  import perf_prof_pkg::*;
  #(parameter int unsigned CNT_W = 32
  )
  (input wire logic clk_i
  , input wire logic rst_i
  , input wire logic clear_i // zero all, beats increments.
  , input wire logic [NUM_CNT_C-1:0] inc_i // one strobe per counter.
  , input wire logic [SEL_W_C-1:0] rd_sel_i
  , output logic [CNT_W-1:0] rd_data_o // one cycle after select.
  );

  localparam logic [CNT_W-1:0] CNT_MAX = '1; // saturation value.

  logic [CNT_W-1:0] cnt_q [NUM_CNT_C]; // counter array.
  logic [CNT_W-1:0] rd_data_q;

  // clear-up counters, saturating at all ones.
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      for (int i = 0; i < NUM_CNT_C; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CNT_C; i++) begin
        if (inc_i[i] && (cnt_q[i] != CNT_MAX)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1; // hold at max.
        end
      end
    end
  end

  // registered read, sees values before this edge's increments.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_data_q <= '0;
    end else if (rd_sel_i < NUM_CNT_C) begin
      rd_data_q <= cnt_q[rd_sel_i];
    end else begin
      rd_data_q <= '0; // unmapped select reads zero.
    end
  end

  assign rd_data_o = rd_data_q;

  a_sel_range: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_sel_i < NUM_CNT_C)
    else $error("read select %0d out of range.", rd_sel_i);

endmodule

`default_nettype wire

// ==== design/event_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module event_decoder
  import perf_prof_pkg::*;
  (input wire logic clk_i
  , input wire logic rst_i
  , input wire logic en_i
  , input wire logic icache_valid_i
  , input wire logic icache_ready_i
  , input wire logic dcache_valid_i
  , input wire logic dcache_ready_i
  , input wire logic m_arvalid_i
  , input wire logic m_arready_i
  , input wire logic m_rvalid_i
  , input wire logic m_rlast_i
  , input wire logic m_awvalid_i
  , input wire logic m_awready_i
  , input wire logic m_bvalid_i
  , input wire logic redirect_v_i // front end command accepted.
  , input wire logic redirect_miss_i // command was a mispredict.
  , input wire logic br_is_br_i
  , input wire logic br_is_jalr_i
  , input wire logic br_is_ret_i
  , output logic ic_miss_o // icache not ready, level.
  , output logic dc_miss_o // dcache not ready, level.
  , output logic dma_pending_o
  , output logic [NUM_EVT_C-1:0] evt_o
  );

  localparam int unsigned EB = CNT_IC_REQ; // counter index of evt_o[0].

  logic ic_ready_q, dc_ready_q; // ready history for edge detect.
  logic rdma_pend_q, wdma_pend_q; // outstanding read, write.
  logic ar_hs, aw_hs; // address handshakes.
  logic r_done, b_done; // final beat, write response.
  logic br_v, jalr_v, ret_v; // classified redirects.
  logic [NUM_EVT_C-1:0] evt_raw; // strobes before enable.

  assign ar_hs = m_arvalid_i & m_arready_i;
  assign aw_hs = m_awvalid_i & m_awready_i;
  assign r_done = m_rvalid_i & m_rlast_i;
  assign b_done = m_bvalid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ic_ready_q <= 1'b1; // no false miss after reset.
      dc_ready_q <= 1'b1;
      rdma_pend_q <= 1'b0;
      wdma_pend_q <= 1'b0;
    end else begin
      ic_ready_q <= icache_ready_i;
      dc_ready_q <= dcache_ready_i;
      if (ar_hs) rdma_pend_q <= 1'b1; // set wins over clear.
      else if (r_done) rdma_pend_q <= 1'b0;
      if (aw_hs) wdma_pend_q <= 1'b1;
      else if (b_done) wdma_pend_q <= 1'b0;
    end
  end

  assign ic_miss_o = ~icache_ready_i;
  assign dc_miss_o = ~dcache_ready_i;
  assign dma_pending_o = rdma_pend_q | wdma_pend_q; // registered value.

  assign br_v = redirect_v_i & br_is_br_i;
  assign jalr_v = redirect_v_i & br_is_jalr_i & ~br_is_ret_i; // returns excluded.
  assign ret_v = redirect_v_i & br_is_ret_i;

  assign evt_raw[CNT_IC_REQ-EB] = icache_valid_i & icache_ready_i;
  assign evt_raw[CNT_IC_MISS-EB] = ~icache_ready_i & ic_ready_q; // falling edge.
  assign evt_raw[CNT_DC_REQ-EB] = dcache_valid_i & dcache_ready_i;
  assign evt_raw[CNT_DC_MISS-EB] = ~dcache_ready_i & dc_ready_q;
  assign evt_raw[CNT_RDMA-EB] = ar_hs;
  assign evt_raw[CNT_WDMA-EB] = aw_hs;
  assign evt_raw[CNT_DMA_WAIT-EB] = dma_pending_o;
  assign evt_raw[CNT_BR-EB] = br_v;
  assign evt_raw[CNT_BR_MISS-EB] = br_v & redirect_miss_i;
  assign evt_raw[CNT_JALR-EB] = jalr_v;
  assign evt_raw[CNT_JALR_MISS-EB] = jalr_v & redirect_miss_i;
  assign evt_raw[CNT_RET-EB] = ret_v;
  assign evt_raw[CNT_RET_MISS-EB] = ret_v & redirect_miss_i;

  assign evt_o = {NUM_EVT_C{en_i}} & evt_raw; // nothing counts when disabled.

  // a miss counter never runs ahead of its total.
  a_miss_implies_cnt: assert property (@(posedge clk_i) disable iff (rst_i)
    (evt_o[CNT_BR_MISS-EB] -> evt_o[CNT_BR-EB])
    && (evt_o[CNT_JALR_MISS-EB] -> evt_o[CNT_JALR-EB])
    && (evt_o[CNT_RET_MISS-EB] -> evt_o[CNT_RET-EB]))
    else $error("branch miss strobe without its count strobe.");

endmodule

`default_nettype wire

// ==== design/stall_classifier.sv ====
`timescale 1ns/10ps
`default_nettype none

module stall_classifier
  import perf_prof_pkg::*;
  (input wire logic clk_i // assertions only.
  , input wire logic rst_i
  , input wire logic en_i
  , input wire logic instret_i
  , input wire logic ic_miss_i // icache not ready.
  , input wire logic mispredict_i
  , input wire logic data_haz_i
  , input wire logic struct_haz_i
  , input wire logic long_haz_i
  , input wire logic dc_miss_i // dcache not ready.
  , input wire logic dma_pending_i // registered pending flags.
  , output logic cyc_inc_o // mcycle increment.
  , output logic ret_inc_o // minstret increment.
  , output logic [NUM_STALL_C-1:0] stall_hot_o
  );

  stall_reason_e reason; // resolved reason this cycle.
  logic stall_v; // enabled cycle with no retirement.

  assign stall_v = en_i & ~instret_i; // only non-retiring cycles are stalls.
  assign cyc_inc_o = en_i; // every enabled cycle counts.
  assign ret_inc_o = en_i & instret_i;

  // fixed priority, first match wins.
  always_comb begin
    if (ic_miss_i) begin
      reason = e_ic_miss;
    end else if (mispredict_i) begin
      reason = e_mispredict;
    end else if (data_haz_i) begin
      reason = e_data_haz;
    end else if (struct_haz_i) begin
      reason = e_struct_haz;
    end else if (long_haz_i) begin
      reason = e_long_haz;
    end else if (dc_miss_i) begin
      reason = e_dc_miss;
    end else if (dma_pending_i) begin
      reason = e_dma_wait;
    end else begin
      reason = e_unknown; // no known cause.
    end
  end

  // expand to one-hot, empty when not stalling.
  always_comb begin
    stall_hot_o = '0;
    if (stall_v) begin
      stall_hot_o[reason] = 1'b1;
    end
  end

  // A stall cycle lands in exactly one stall counter, so the stall counters
  // sum to mcycle minus minstret.
  a_stall_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(stall_hot_o) && (instret_i -> (stall_hot_o == '0)))
    else $error("stall strobe not one-hot or set on retire.");

endmodule

`default_nettype wire

// ==== design/perf_prof_pkg.sv ====
`default_nettype none

package perf_prof_pkg;

  localparam int unsigned NUM_CNT_C = 23; // total counters in the bank.
  localparam int unsigned SEL_W_C = 5; // read select width.

  // counter map, as seen on the read port.
  localparam int unsigned CNT_MCYCLE = 0; // enabled cycles.
  localparam int unsigned CNT_MINSTRET = 1; // retired instructions.
  localparam int unsigned CNT_STALL_BASE = 2; // first of eight stall reasons.
  localparam int unsigned CNT_IC_REQ = 10; // icache accepted requests.
  localparam int unsigned CNT_IC_MISS = 11; // icache ready falling edges.
  localparam int unsigned CNT_DC_REQ = 12; // dcache accepted requests.
  localparam int unsigned CNT_DC_MISS = 13; // dcache ready falling edges.
  localparam int unsigned CNT_RDMA = 14; // ar handshakes.
  localparam int unsigned CNT_WDMA = 15; // aw handshakes.
  localparam int unsigned CNT_DMA_WAIT = 16; // cycles with dma outstanding.
  localparam int unsigned CNT_BR = 17; // resolved conditional branches.
  localparam int unsigned CNT_BR_MISS = 18;
  localparam int unsigned CNT_JALR = 19; // indirect jumps, returns excluded.
  localparam int unsigned CNT_JALR_MISS = 20;
  localparam int unsigned CNT_RET = 21; // returns.
  localparam int unsigned CNT_RET_MISS = 22;

  localparam int unsigned NUM_STALL_C = 8; // stall reasons.

  // Stall reasons, highest priority first. The encoding is also the bit
  // position in the one-hot stall strobe.
  typedef enum logic [2:0] {
    e_ic_miss = 3'd0, // fetch starved by icache.
    e_mispredict = 3'd1, // front end redirected.
    e_data_haz = 3'd2, // operand not ready.
    e_struct_haz = 3'd3, // unit busy.
    e_long_haz = 3'd4, // long latency op in flight.
    e_dc_miss = 3'd5, // dcache not ready.
    e_dma_wait = 3'd6, // bus traffic outstanding.
    e_unknown = 3'd7 // nothing above matched.
  } stall_reason_e;

  localparam int unsigned NUM_EVT_C = 13; // event strobes, counters 10 to 22.

endpackage

`default_nettype wire
